//--- source/i2c_pkg.sv
package i2c_pkg;

    // bus timing, kept fast for simulation
    localparam int sys_clk_hz = 250_000_000;
    localparam int scl_hz     = 2_500_000;

    // cycles per scl half period, rounded up
    localparam int half_period   = (sys_clk_hz + 2 * scl_hz - 1) / (2 * scl_hz);
    localparam int half_period_w = $clog2(half_period);

    // timer values for the end and the middle of a half period
    localparam logic [half_period_w-1:0] tick_last = half_period_w'(half_period - 1);
    localparam logic [half_period_w-1:0] tick_mid  = half_period_w'(half_period / 2);

    // read fifo, depth must be a power of two
    localparam int rd_fifo_depth = 4;
    localparam int rd_fifo_aw    = $clog2(rd_fifo_depth);

    localparam int len_w  = 8;
    localparam int addr_w = 7;

    // r/w bit of the address byte
    localparam logic rw_write = 1'b0;
    localparam logic rw_read  = 1'b1;

    typedef enum logic [3:0] {
        idle,
        start_hi,
        start_fall,
        start_hold,
        addr_load,
        byte_load,
        bit_low,
        bit_high,
        ack_low,
        ack_high,
        ack_check,
        restart,
        stop_prep,
        stop_rise,
        finish
    } engine_state_t;

endpackage

//--- source/i2c_pins.sv
`timescale 1ns/1ps

module i2c_pins (
    input  logic clk,
    input  logic rst_n,
    input  logic sda_low,
    input  logic scl_low,
    inout  tri   sda_io,
    inout  tri   scl_io,
    output logic sda_in,
    output logic scl_in,
    output logic scl_rise
);

    logic [1:0] meta;  // {sda, scl} first stage
    logic [1:0] sync;  // {sda, scl} second stage
    logic       scl_in_d;

    // open drain, pull-ups are external
    assign sda_io = sda_low ? 1'b0 : 1'bz;
    assign scl_io = scl_low ? 1'b0 : 1'bz;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            meta <= 2'b11;  // idle bus reads high
            sync <= 2'b11;
        end else begin
            meta <= {sda_io, scl_io};
            sync <= meta;
        end
    end

    assign sda_in = sync[1];
    assign scl_in = sync[0];

    // registered edge pulse, one cycle after scl_in rises
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scl_in_d <= 1'b1;
            scl_rise <= 1'b0;
        end else begin
            scl_in_d <= scl_in;
            scl_rise <= scl_in & ~scl_in_d;
        end
    end

endmodule

//--- source/i2c_engine.sv
`timescale 1ns/1ps

module i2c_engine (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic [i2c_pkg::addr_w-1:0]  addr7,
    input  logic [i2c_pkg::len_w-1:0]   wr_len,
    input  logic [i2c_pkg::len_w-1:0]   rd_len,
    input  logic [7:0]                  wr_data,
    input  logic                        wr_valid,
    input  logic                        sda_in,
    input  logic                        scl_in,
    input  logic                        scl_rise,
    input  logic                        rd_full,
    output logic                        busy,
    output logic                        done,
    output logic                        nack_addr,
    output logic                        nack_data,
    output logic                        wr_ready,
    output logic                        sda_low,
    output logic                        scl_low,
    output logic                        push,
    output logic [7:0]                  push_data
);

    i2c_pkg::engine_state_t state;
    i2c_pkg::engine_state_t next;

    logic                              start_q;
    logic                              start_qq;
    logic                              start_pulse;
    logic                              start_ok;
    logic [i2c_pkg::half_period_w-1:0] cnt;
    logic                              tick;
    logic                              mid;
    logic                              phase_wait;
    logic                              rise_seen;
    logic [2:0]                        bit_cnt;
    logic [7:0]                        tx_sr;
    logic [7:0]                        rx_sr;
    logic [i2c_pkg::len_w-1:0]         wr_rem;
    logic [i2c_pkg::len_w-1:0]         rd_rem;
    logic                              addr_byte;
    logic                              rd_phase;
    logic                              rx_byte;
    logic                              ack_bit;
    logic                              ack_nack;
    logic                              wr_accept;
    logic                              byte_end;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_q  <= 1'b0;
            start_qq <= 1'b0;
        end else begin
            start_q  <= start;
            start_qq <= start_q;
        end
    end

    assign start_pulse = start_q & ~start_qq;
    assign start_ok    = start_pulse && (state == i2c_pkg::idle) &&
                         ((wr_len != '0) || (rd_len != '0));

    assign rx_byte   = rd_phase && !addr_byte;  // master receives this byte
    assign ack_nack  = ack_bit && !rx_byte;
    assign wr_ready  = (state == i2c_pkg::byte_load);
    assign wr_accept = wr_ready && wr_valid;
    assign byte_end  = (state == i2c_pkg::bit_high) && (next == i2c_pkg::ack_low);
    assign push_data = rx_sr;

    // hold the timer while the line is not yet where it should be
    always_comb begin
        case (state)
            i2c_pkg::start_hi:  phase_wait = !(scl_in && sda_in);
            i2c_pkg::bit_high,
            i2c_pkg::ack_high:  phase_wait = !rise_seen;  // slave may stretch scl
            i2c_pkg::stop_rise: phase_wait = !scl_in;
            default:            phase_wait = 1'b0;
        endcase
    end

    assign tick = (cnt == i2c_pkg::tick_last) && !phase_wait;
    assign mid  = (cnt == i2c_pkg::tick_mid);

    // half period timer, restarts at every phase change
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt       <= '0;
            rise_seen <= 1'b0;
        end else begin
            if (state != next || phase_wait || tick)
                cnt <= '0;
            else
                cnt <= cnt + 1'b1;

            if (state != next)
                rise_seen <= 1'b0;
            else if (scl_rise)
                rise_seen <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= i2c_pkg::idle;
        else
            state <= next;
    end

    always_comb begin
        next = state;
        case (state)
            i2c_pkg::idle:       if (start_ok)  next = i2c_pkg::start_hi;
            i2c_pkg::start_hi:   if (tick)      next = i2c_pkg::start_fall;
            i2c_pkg::start_fall:                next = i2c_pkg::start_hold;
            i2c_pkg::start_hold: if (tick)      next = i2c_pkg::addr_load;
            i2c_pkg::addr_load:                 next = i2c_pkg::bit_low;
            i2c_pkg::byte_load:  if (wr_accept) next = i2c_pkg::bit_low;
            i2c_pkg::bit_low:    if (tick)      next = i2c_pkg::bit_high;
            i2c_pkg::bit_high: begin
                if (tick)
                    next = (bit_cnt == 3'd7) ? i2c_pkg::ack_low : i2c_pkg::bit_low;
            end
            i2c_pkg::ack_low:    if (tick)      next = i2c_pkg::ack_high;
            i2c_pkg::ack_high:   if (tick)      next = i2c_pkg::ack_check;
            i2c_pkg::ack_check: begin
                if (ack_nack)
                    next = i2c_pkg::stop_prep;
                else if (!rd_phase) begin
                    if (wr_rem != '0)
                        next = i2c_pkg::byte_load;
                    else if (rd_rem != '0)
                        next = i2c_pkg::restart;  // combined transfer
                    else
                        next = i2c_pkg::stop_prep;
                end else if (rd_rem == '0)
                    next = i2c_pkg::stop_prep;
                else if (!rd_full)
                    next = i2c_pkg::bit_low;  // otherwise stall with scl low
            end
            i2c_pkg::restart:    if (tick)      next = i2c_pkg::start_hi;
            i2c_pkg::stop_prep:  if (tick)      next = i2c_pkg::stop_rise;
            i2c_pkg::stop_rise:  if (tick)      next = i2c_pkg::finish;
            i2c_pkg::finish:                    next = i2c_pkg::idle;
            default:                            next = i2c_pkg::idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            done      <= 1'b0;
            nack_addr <= 1'b0;
            nack_data <= 1'b0;
            sda_low   <= 1'b0;
            scl_low   <= 1'b0;
            push      <= 1'b0;
            wr_rem    <= '0;
            rd_rem    <= '0;
            bit_cnt   <= '0;
            addr_byte <= 1'b0;
            rd_phase  <= 1'b0;
            ack_bit   <= 1'b0;
        end else begin
            done <= 1'b0;
            push <= 1'b0;

            if (start_ok) begin
                busy      <= 1'b1;
                nack_addr <= 1'b0;
                nack_data <= 1'b0;
                wr_rem    <= wr_len;
                rd_rem    <= rd_len;
            end

            // actions on entry to a state
            if (state != next) begin
                case (next)
                    i2c_pkg::start_hi: begin
                        scl_low <= 1'b0;
                        sda_low <= 1'b0;
                    end
                    i2c_pkg::start_fall: sda_low <= 1'b1;  // start condition
                    i2c_pkg::addr_load,
                    i2c_pkg::byte_load,
                    i2c_pkg::bit_low,
                    i2c_pkg::ack_low,
                    i2c_pkg::ack_check,
                    i2c_pkg::restart,
                    i2c_pkg::stop_prep: scl_low <= 1'b1;
                    i2c_pkg::bit_high,
                    i2c_pkg::ack_high,
                    i2c_pkg::stop_rise: scl_low <= 1'b0;
                    i2c_pkg::finish: begin
                        sda_low <= 1'b0;  // stop condition
                        done    <= 1'b1;
                    end
                    i2c_pkg::idle: busy <= 1'b0;
                    default: ;
                endcase
            end

            // sda moves only in the middle of a low phase
            if (mid) begin
                case (state)
                    i2c_pkg::bit_low:   sda_low <= rx_byte ? 1'b0 : ~tx_sr[7];
                    i2c_pkg::ack_low:   sda_low <= rx_byte && (rd_rem != '0);  // nack last
                    i2c_pkg::restart:   sda_low <= 1'b0;
                    i2c_pkg::stop_prep: sda_low <= 1'b1;
                    default: ;
                endcase
            end

            if (state == i2c_pkg::addr_load) begin
                addr_byte <= 1'b1;
                rd_phase  <= (wr_rem == '0);
                bit_cnt   <= '0;
            end else if (state == i2c_pkg::bit_high && tick) begin
                bit_cnt <= bit_cnt + 1'b1;
            end

            if (wr_accept)
                wr_rem <= wr_rem - 1'b1;

            if (byte_end && rx_byte) begin
                push   <= 1'b1;
                rd_rem <= rd_rem - 1'b1;
            end

            if (state == i2c_pkg::ack_high && scl_rise)
                ack_bit <= sda_in;

            if (state == i2c_pkg::ack_check) begin
                if (ack_nack) begin
                    if (addr_byte)
                        nack_addr <= 1'b1;
                    else
                        nack_data <= 1'b1;
                end
                if (next != i2c_pkg::ack_check)
                    addr_byte <= 1'b0;
            end
        end
    end

    // shift registers
    always_ff @(posedge clk) begin
        if (state == i2c_pkg::addr_load)
            tx_sr <= {addr7, (wr_rem == '0) ? i2c_pkg::rw_read : i2c_pkg::rw_write};
        else if (wr_accept)
            tx_sr <= wr_data;
        else if (state == i2c_pkg::bit_high && tick)
            tx_sr <= {tx_sr[6:0], 1'b0};

        if (state == i2c_pkg::bit_high && scl_rise)
            rx_sr <= {rx_sr[6:0], sda_in};  // msb first
    end

endmodule

//--- source/i2c_rd_fifo.sv
`timescale 1ns/1ps

module i2c_rd_fifo (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       push,
    input  logic [7:0] push_data,
    input  logic       rd_ready,
    output logic       full,
    output logic [7:0] rd_data,
    output logic       rd_valid
);

    logic [7:0]                    mem [i2c_pkg::rd_fifo_depth];
    logic [i2c_pkg::rd_fifo_aw-1:0] wr_ptr;
    logic [i2c_pkg::rd_fifo_aw-1:0] rd_ptr;
    logic [i2c_pkg::rd_fifo_aw:0]   count;
    logic                           wr_en;
    logic                           rd_en;

    assign full     = count[i2c_pkg::rd_fifo_aw];  // count == depth
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];

    assign wr_en = push && !full;
    assign rd_en = rd_valid && rd_ready;

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr] <= push_data;
    end

    // pointers wrap naturally
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;

            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- source/i2c_master.sv
`timescale 1ns/1ps

module i2c_master (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic [i2c_pkg::addr_w-1:0]  addr7,
    input  logic [i2c_pkg::len_w-1:0]   wr_len,
    input  logic [i2c_pkg::len_w-1:0]   rd_len,
    input  logic [7:0]                  wr_data,
    input  logic                        wr_valid,
    input  logic                        rd_ready,
    output logic                        busy,
    output logic                        done,
    output logic                        nack_addr,
    output logic                        nack_data,
    output logic                        wr_ready,
    output logic [7:0]                  rd_data,
    output logic                        rd_valid,
    inout  tri                          sda_io,
    inout  tri                          scl_io
);

    logic       sda_low;
    logic       scl_low;
    logic       sda_in;
    logic       scl_in;
    logic       scl_rise;
    logic       push;
    logic [7:0] push_data;
    logic       rd_full;

    i2c_pins u_pins (
        .clk      (clk),
        .rst_n    (rst_n),
        .sda_low  (sda_low),
        .scl_low  (scl_low),
        .sda_io   (sda_io),
        .scl_io   (scl_io),
        .sda_in   (sda_in),
        .scl_in   (scl_in),
        .scl_rise (scl_rise)
    );

    i2c_engine u_engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .addr7     (addr7),
        .wr_len    (wr_len),
        .rd_len    (rd_len),
        .wr_data   (wr_data),
        .wr_valid  (wr_valid),
        .sda_in    (sda_in),
        .scl_in    (scl_in),
        .scl_rise  (scl_rise),
        .rd_full   (rd_full),
        .busy      (busy),
        .done      (done),
        .nack_addr (nack_addr),
        .nack_data (nack_data),
        .wr_ready  (wr_ready),
        .sda_low   (sda_low),
        .scl_low   (scl_low),
        .push      (push),
        .push_data (push_data)
    );

    i2c_rd_fifo u_rd_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .rd_ready  (rd_ready),
        .full      (rd_full),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid)
    );

endmodule

//--- verification/i2c_slave_model.sv
`timescale 1ns/1ps

module i2c_slave_model #(
    parameter logic [6:0] own_addr = 7'h52
) (
    input  logic clk,
    input  logic rst_n,
    inout  tri   sda_io,
    inout  tri   scl_io
);

    localparam int st_idle    = 0;
    localparam int st_rx      = 1;
    localparam int st_ack_out = 2;
    localparam int st_tx      = 3;
    localparam int st_ack_in  = 4;

    logic [7:0] rx_bytes [$];    // write data seen on the bus
    logic       rw_bits [$];     // r/w bit of each matched address
    logic       master_ack [$];  // sda level in the ack slot of read bytes
    logic [7:0] rd_script [$];
    int         nack_index;      // write byte index to refuse or -1
    bit         stretch_en;
    int         starts;
    int         restarts;
    int         stops;
    int         seed;

    int         state;
    int         bit_cnt;
    int         wr_idx;
    int         rd_idx;
    int         hold;
    logic [7:0] sr;
    logic       is_addr;
    logic       rw;
    logic       in_frame;
    logic       last_ack;
    logic       sda_drive;
    logic       scl_drive;
    logic       sda_q;
    logic       scl_q;
    logic       sda_s;
    logic       scl_s;

    assign sda_io = sda_drive ? 1'b0 : 1'bz;
    assign scl_io = scl_drive ? 1'b0 : 1'bz;
    assign sda_s  = (sda_io !== 1'b0);
    assign scl_s  = (scl_io !== 1'b0);

    initial seed = 32'hb72c844f;

    function automatic logic [7:0] script_byte(input int i);
        return (i < rd_script.size()) ? rd_script[i] : 8'hff;
    endfunction

    always @(posedge clk or negedge rst_n) begin : bus
        int         stretch;
        logic [7:0] nxt_byte;
        if (!rst_n) begin
            state     <= st_idle;
            bit_cnt   <= 0;
            hold      <= 0;
            starts    <= 0;
            in_frame  <= 1'b0;
            sda_drive <= 1'b0;
            scl_drive <= 1'b0;
            sda_q     <= 1'b1;
            scl_q     <= 1'b1;
        end else begin
            sda_q <= sda_s;
            scl_q <= scl_s;
            if (hold > 1) begin
                hold <= hold - 1;
            end else if (hold == 1) begin
                hold      <= 0;
                scl_drive <= 1'b0;
            end

            if (scl_s && scl_q && sda_q && !sda_s) begin  // start or repeated start
                if (in_frame) begin
                    restarts <= restarts + 1;
                end else begin
                    starts   <= starts + 1;
                    restarts <= 0;
                    stops    <= 0;
                    wr_idx   <= 0;
                    rd_idx   <= 0;
                end
                in_frame  <= 1'b1;
                state     <= st_rx;
                bit_cnt   <= 0;
                is_addr   <= 1'b1;
                sda_drive <= 1'b0;
            end else if (scl_s && scl_q && !sda_q && sda_s) begin  // stop
                stops     <= stops + 1;
                in_frame  <= 1'b0;
                state     <= st_idle;
                sda_drive <= 1'b0;
            end else if (scl_s && !scl_q) begin
                if (state == st_rx) begin
                    sr      <= {sr[6:0], sda_s};
                    bit_cnt <= bit_cnt + 1;
                end else if (state == st_ack_in) begin
                    master_ack.push_back(sda_s);
                    last_ack <= sda_s;
                end
            end else if (!scl_s && scl_q) begin
                if (stretch_en && ($random(seed) & 1)) begin
                    stretch   = ($random(seed) & 3) * i2c_pkg::half_period;
                    hold      <= stretch;
                    scl_drive <= (stretch != 0);
                end
                case (state)
                    st_rx: if (bit_cnt == 8) begin
                        if (is_addr) begin
                            if (sr[7:1] == own_addr) begin
                                rw        <= sr[0];
                                rw_bits.push_back(sr[0]);
                                sda_drive <= 1'b1;
                                state     <= st_ack_out;
                            end else begin
                                state <= st_idle;  // not ours so sda stays released
                            end
                        end else begin
                            rx_bytes.push_back(sr);
                            wr_idx <= wr_idx + 1;
                            if (wr_idx == nack_index) begin
                                state <= st_idle;
                            end else begin
                                sda_drive <= 1'b1;
                                state     <= st_ack_out;
                            end
                        end
                    end
                    st_ack_out: begin
                        bit_cnt <= 0;
                        is_addr <= 1'b0;
                        if (is_addr && rw) begin
                            nxt_byte  = script_byte(rd_idx);
                            sr        <= nxt_byte;
                            sda_drive <= !nxt_byte[7];
                            rd_idx    <= rd_idx + 1;
                            state     <= st_tx;
                        end else begin
                            sda_drive <= 1'b0;
                            state     <= st_rx;
                        end
                    end
                    st_tx: begin
                        if (bit_cnt == 7) begin
                            sda_drive <= 1'b0;
                            state     <= st_ack_in;
                        end else begin
                            sda_drive <= !sr[6];
                            sr        <= {sr[6:0], 1'b0};
                            bit_cnt   <= bit_cnt + 1;
                        end
                    end
                    st_ack_in: begin
                        if (!last_ack) begin  // master wants more
                            nxt_byte  = script_byte(rd_idx);
                            sr        <= nxt_byte;
                            sda_drive <= !nxt_byte[7];
                            rd_idx    <= rd_idx + 1;
                            bit_cnt   <= 0;
                            state     <= st_tx;
                        end else begin
                            state <= st_idle;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- verification/tb_i2c_master.sv
`timescale 1ns/1ps

module tb_i2c_master;

    localparam logic [6:0] slave_addr  = 7'h52;
    localparam int         total_bytes = 38;  // all lengths plus one address per transfer
    localparam longint     watchdog_ns = longint'(total_bytes) * 9 * 2 *
                                         i2c_pkg::half_period * 4 * 4;

    logic       clk;
    logic       rst_n;
    logic       start;
    logic [6:0] addr7;
    logic [7:0] wr_len;
    logic [7:0] rd_len;
    logic [7:0] wr_data;
    logic       wr_valid;
    logic       rd_ready;
    logic       busy;
    logic       done;
    logic       nack_addr;
    logic       nack_data;
    logic       wr_ready;
    logic [7:0] rd_data;
    logic       rd_valid;
    wire        sda_io;
    wire        scl_io;

    int         errors;
    int         seed;
    logic [7:0] wr_q [$];
    logic [7:0] sent_q [$];
    logic [7:0] exp_rd [$];
    logic [7:0] got_q [$];

    pullup (sda_io);
    pullup (scl_io);

    i2c_master i_i2c_master (.*);

    i2c_slave_model #(.own_addr(slave_addr)) i_slave (
        .clk    (clk),
        .rst_n  (rst_n),
        .sda_io (sda_io),
        .scl_io (scl_io)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    assert property (@(posedge clk) disable iff (!rst_n) done |=> !done && !busy)
        else begin
            errors++;
            $display("done lasted more than one cycle or busy stayed high at %0t", $time);
        end

    // scl held low while the engine stalls on a full FIFO
    assert property (@(posedge clk) disable iff (!rst_n)
        (i_i2c_master.u_engine.state == i2c_pkg::ack_check && i_i2c_master.u_rd_fifo.full)
        |-> !scl_io)
        else begin
            errors++;
            $display("scl released during a read stall at %0t", $time);
        end

    task automatic check_value(input string name, input int exp, input int act);
        assert (exp == act) else begin
            errors++;
            $display("Mismatch at %0t: %s expected %0h got %0h", $time, name, exp, act);
        end
    endtask

    task automatic run_transfer(input logic [6:0] addr, input int wlen, input int rlen,
                                input int nack_at, input bit hold_rd);
        int  idx;
        int  hold_cnt;
        int  n_wr;
        int  n_rd;
        int  starts_before;
        bit  took;
        bit  fin;
        bit  release_rd;
        bit  saw_wr_ready;
        bit  seen_busy;
        bit  na;
        bit  nd;
        bit  exp_na;
        bit  exp_nd;
        idx = 0;
        hold_cnt = 0;
        fin = 0;
        release_rd = 0;
        saw_wr_ready = 0;
        seen_busy = 0;
        starts_before = i_slave.starts;
        exp_na = (addr != slave_addr);
        exp_nd = !exp_na && (nack_at >= 0);
        wr_q.delete();
        sent_q.delete();
        exp_rd.delete();
        got_q.delete();
        i_slave.rx_bytes.delete();
        i_slave.rw_bits.delete();
        i_slave.master_ack.delete();
        i_slave.rd_script.delete();
        i_slave.nack_index = nack_at;
        for (int i = 0; i < wlen; i++)
            wr_q.push_back(8'($random(seed)));
        for (int i = 0; i < rlen; i++) begin
            exp_rd.push_back(8'($random(seed)));
            i_slave.rd_script.push_back(exp_rd[i]);
        end

        @(posedge clk);
        start    <= 1'b1;
        addr7    <= addr;
        wr_len   <= 8'(wlen);
        rd_len   <= 8'(rlen);
        wr_valid <= (wlen > 0);
        wr_data  <= (wlen > 0) ? wr_q[0] : 8'h00;
        rd_ready <= !hold_rd;
        @(posedge clk);
        start <= 1'b0;
        while (!fin) begin
            @(negedge clk);
            took = wr_ready && wr_valid;
            if (wr_ready)
                saw_wr_ready = 1;
            if (took)
                sent_q.push_back(wr_data);
            if (rd_valid && rd_ready)
                got_q.push_back(rd_data);
            assert (busy || !seen_busy) else begin
                errors++;
                $display("busy fell before done at %0t", $time);
            end
            if (busy)
                seen_busy = 1;
            if (hold_rd && !rd_ready && !release_rd) begin
                if (i_i2c_master.u_rd_fifo.full)
                    hold_cnt++;
                if (hold_cnt == 10 * i2c_pkg::half_period) begin
                    assert (busy && i_i2c_master.u_engine.state == i2c_pkg::ack_check)
                        else begin
                            errors++;
                            $display("engine not stalled with a full FIFO at %0t", $time);
                        end
                    release_rd = 1;
                end
            end
            if (done) begin
                fin = 1;
                na  = nack_addr;
                nd  = nack_data;
            end
            @(posedge clk);
            if (took)
                idx++;
            wr_valid <= (idx < wlen) && (($random(seed) & 3) != 0);  // random gaps
            wr_data  <= (idx < wlen) ? wr_q[idx] : 8'h00;
            if (release_rd)
                rd_ready <= 1'b1;
        end
        rd_ready <= 1'b1;
        wr_valid <= 1'b0;
        repeat (8) begin
            @(negedge clk);
            if (rd_valid && rd_ready)
                got_q.push_back(rd_data);
        end

        if (hold_rd)
            assert (release_rd) else begin
                errors++;
                $display("read stall with a full FIFO never happened at %0t", $time);
            end
        check_value("nack_addr", exp_na, na);
        check_value("nack_data", exp_nd, nd);
        if (exp_na)
            check_value("wr_ready seen", 0, saw_wr_ready);
        n_wr = exp_na ? 0 : (exp_nd ? nack_at + 1 : wlen);
        n_rd = (exp_na || exp_nd) ? 0 : rlen;
        check_value("write byte count", n_wr, sent_q.size());
        check_value("slave byte count", n_wr, i_slave.rx_bytes.size());
        for (int i = 0; i < n_wr && i < sent_q.size(); i++) begin
            check_value("wr_data", wr_q[i], sent_q[i]);
            if (i < i_slave.rx_bytes.size())
                check_value("slave rx byte", wr_q[i], i_slave.rx_bytes[i]);
        end
        check_value("read byte count", n_rd, got_q.size());
        for (int i = 0; i < n_rd && i < got_q.size(); i++)
            check_value("rd_data", exp_rd[i], got_q[i]);
        if (n_rd > 0) begin
            check_value("ack slot count", n_rd, i_slave.master_ack.size());
            for (int i = 0; i < n_rd && i < i_slave.master_ack.size(); i++)
                check_value("master ack bit", (i == n_rd - 1), i_slave.master_ack[i]);
        end
        check_value("address count", (exp_na ? 0 : 1) + ((n_rd > 0 && wlen > 0) ? 1 : 0),
                    i_slave.rw_bits.size());
        if (!exp_na && i_slave.rw_bits.size() > 0)
            check_value("first r/w bit", (wlen > 0) ? i2c_pkg::rw_write : i2c_pkg::rw_read,
                        i_slave.rw_bits[0]);
        if (i_slave.rw_bits.size() > 1)
            check_value("second r/w bit", i2c_pkg::rw_read, i_slave.rw_bits[1]);
        check_value("start count", 1, i_slave.starts - starts_before);
        check_value("stop count", 1, i_slave.stops);
        check_value("restart count", (wlen > 0 && n_rd > 0), i_slave.restarts);
    endtask

    initial begin
        errors   = 0;
        seed     = 32'hb72c844f;
        rst_n    = 1'b0;
        start    = 1'b0;
        addr7    = '0;
        wr_len   = '0;
        rd_len   = '0;
        wr_data  = '0;
        wr_valid = 1'b0;
        rd_ready = 1'b0;
        i_slave.nack_index = -1;
        i_slave.stretch_en = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("busy", 0, busy);
        check_value("done", 0, done);
        check_value("wr_ready", 0, wr_ready);
        check_value("rd_valid", 0, rd_valid);
        check_value("nack_addr", 0, nack_addr);
        check_value("nack_data", 0, nack_data);
        check_value("sda_io", 1, sda_io);
        check_value("scl_io", 1, scl_io);

        run_transfer(slave_addr, 5, 0, -1, 1'b0);
        run_transfer(slave_addr, 0, 3, -1, 1'b0);
        run_transfer(slave_addr, 3, 4, -1, 1'b0);
        run_transfer(7'h13, 2, 2, -1, 1'b0);     // nobody answers
        run_transfer(slave_addr, 4, 0, 1, 1'b0);
        i_slave.stretch_en = 1'b1;
        run_transfer(slave_addr, 0, 9, -1, 1'b1);

        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("Timeout: transfers did not complete in time, errors so far %0d", errors);
        $display("Verification failed");
        $finish;
    end

endmodule

//--- vlog.f
source/i2c_pkg.sv
source/i2c_pins.sv
source/i2c_engine.sv
source/i2c_rd_fifo.sv
source/i2c_master.sv
verification/i2c_slave_model.sv
verification/tb_i2c_master.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_i2c_master
RTL_TOP   ?= i2c_master
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	fi
	@grep -q "Verification passed" $(LOG) || (echo "no result in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
